//--- src/ring_bus_pkg.sv
// Ring bus stream switch package.
// Station counts, widths, id and data types, and the beat and slot
// structs that travel through the source and sink stations of the ring.

package ring_bus_pkg;

	// ##################################################
	// sizes

	localparam int src_num      = 4;                  // source stations.
	localparam int dst_num      = 3;                  // sink stations.
	localparam int station_num  = src_num + dst_num;  // slots on the ring.
	localparam int data_width   = 16;
	localparam int src_id_width = 2;
	localparam int dst_id_width = 2;

	// ##################################################
	// types

	typedef logic [src_id_width-1:0] src_id_t;
	typedef logic [dst_id_width-1:0] dst_id_t;  // dst_num and above are illegal.
	typedef logic [data_width-1:0]   data_t;

	// beat entering at a source port.
	typedef struct packed {
		dst_id_t dst_id;
		logic    last;
		data_t   data;
	} src_beat_t;

	// beat leaving at a sink port.
	typedef struct packed {
		src_id_t src_id;
		logic    last;
		data_t   data;
	} dst_beat_t;

	// one ring slot, moved one station per advance.
	typedef struct packed {
		logic    valid;
		logic    last;
		dst_id_t dst_id;
		src_id_t src_id;
		data_t   data;
	} ring_slot_t;

endpackage

//--- src/ring_bus_source_station.sv
// Ring bus source station.
// Holds one slot of the ring. While this station owns the token it puts
// beats from its stream port into empty slots, tagged with its own
// source number. The token is handed to the next source station once
// the last beat of a packet is on the ring, or when no beat is offered.

`timescale 1ns/1ps

module ring_bus_source_station #(
	parameter int station_id = 0
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     advance,

	input  ring_bus_pkg::src_beat_t  s_beat,
	input  logic                     s_valid,
	output logic                     s_ready,

	input  ring_bus_pkg::ring_slot_t ring_in,
	output ring_bus_pkg::ring_slot_t ring_out,

	input  logic                     token_in,
	output logic                     token_out
);
	import ring_bus_pkg::*;

	ring_slot_t slot_d;
	ring_slot_t slot_q;
	logic       token_q;
	logic       accept;

	// ##################################################
	// injection

	// only the token holder may fill an empty slot.
	assign s_ready = advance && token_q && !ring_in.valid;
	assign accept  = s_valid && s_ready;

	always_comb begin
		slot_d = ring_in;  // default is pass-through.
		if (accept) begin
			slot_d.valid  = 1'b1;
			slot_d.last   = s_beat.last;
			slot_d.dst_id = s_beat.dst_id;
			slot_d.src_id = src_id_t'(station_id);
			slot_d.data   = s_beat.data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_q.valid <= 1'b0;
		end else if (advance) begin
			slot_q <= slot_d;
		end
	end

	assign ring_out = slot_q;

	// ##################################################
	// token

	// keep the token while a packet is still open.
	assign token_out = advance && token_q && (!s_valid || (accept && s_beat.last));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			token_q <= (station_id == 0);  // source 0 starts with it.
		end else if (advance) begin
			token_q <= token_in || (token_q && !token_out);
		end
	end

	// ##################################################
	// checks

	// the source port only ever names an existing sink.
	a_dst_legal: assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> (s_beat.dst_id < dst_id_t'(dst_num)));

	// a beat already on the ring leaves this station untouched.
	a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
		(advance && ring_in.valid) |=> (ring_out == $past(ring_in)));

endmodule

//--- src/ring_bus_sink_station.sv
// Ring bus sink station.
// Holds one slot of the ring and hands slots addressed to its sink
// number to the stream port. While the consumer refuses a beat the
// station asks for a ring stall, so the beat waits in place.

`timescale 1ns/1ps

module ring_bus_sink_station #(
	parameter int station_id = 0
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     advance,

	input  ring_bus_pkg::ring_slot_t ring_in,
	output ring_bus_pkg::ring_slot_t ring_out,

	output ring_bus_pkg::dst_beat_t  m_beat,
	output logic                     m_valid,
	input  logic                     m_ready,

	output logic                     stall
);
	import ring_bus_pkg::*;

	ring_slot_t slot_d;
	ring_slot_t slot_q;
	logic       match;
	logic       handoff;
	logic       taken_q;

	// ##################################################
	// ejection

	assign match   = ring_in.valid && (ring_in.dst_id == dst_id_t'(station_id));
	assign m_valid = match && !taken_q;
	assign handoff = m_valid && m_ready;
	assign stall   = m_valid && !m_ready;  // refused beat freezes the ring.

	assign m_beat = '{src_id: ring_in.src_id, last: ring_in.last, data: ring_in.data};

	// a beat can be taken while another sink holds the ring still;
	// remember it so it is not offered a second time.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			taken_q <= 1'b0;
		end else if (advance) begin
			taken_q <= 1'b0;
		end else if (handoff) begin
			taken_q <= 1'b1;
		end
	end

	always_comb begin
		slot_d = ring_in;
		if (handoff || taken_q) begin
			slot_d.valid = 1'b0;  // delivered, slot goes on empty.
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_q.valid <= 1'b0;
		end else if (advance) begin
			slot_q <= slot_d;
		end
	end

	assign ring_out = slot_q;

	// ##################################################
	// checks

	// a waiting beat stays put until the consumer takes it.
	a_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_beat)));

endmodule

//--- src/ring_bus_switch.sv
// Ring bus stream switch.
// Four source stations and three sink stations form one closed ring of
// slot registers. A single token circulates among the source stations
// and decides who may inject. Any sink whose consumer refuses a beat
// stalls the whole ring for that cycle.

`timescale 1ns/1ps

module ring_bus_switch (
	input  logic                               clk,
	input  logic                               rst_n,

	input  ring_bus_pkg::src_beat_t            s_beat [ring_bus_pkg::src_num],
	input  logic [ring_bus_pkg::src_num-1:0]   s_valid,
	output logic [ring_bus_pkg::src_num-1:0]   s_ready,

	output ring_bus_pkg::dst_beat_t            m_beat [ring_bus_pkg::dst_num],
	output logic [ring_bus_pkg::dst_num-1:0]   m_valid,
	input  logic [ring_bus_pkg::dst_num-1:0]   m_ready
);
	import ring_bus_pkg::*;

	ring_slot_t         ring_link [station_num+1];  // entry k feeds station k.
	logic [src_num:0]   token_link;
	logic [dst_num-1:0] stall;
	logic               advance;

	// ##################################################
	// source stations

	for (genvar i = 0; i < src_num; i++) begin : gen_src
		ring_bus_source_station #(
			.station_id (i)
		) u_src (
			.clk       (clk),
			.rst_n     (rst_n),
			.advance   (advance),
			.s_beat    (s_beat[i]),
			.s_valid   (s_valid[i]),
			.s_ready   (s_ready[i]),
			.ring_in   (ring_link[i]),
			.ring_out  (ring_link[i+1]),
			.token_in  (token_link[i]),
			.token_out (token_link[i+1])
		);
	end

	assign token_link[0] = token_link[src_num];  // token loop.

	// ##################################################
	// sink stations

	for (genvar j = 0; j < dst_num; j++) begin : gen_dst
		ring_bus_sink_station #(
			.station_id (j)
		) u_dst (
			.clk      (clk),
			.rst_n    (rst_n),
			.advance  (advance),
			.ring_in  (ring_link[src_num+j]),
			.ring_out (ring_link[src_num+j+1]),
			.m_beat   (m_beat[j]),
			.m_valid  (m_valid[j]),
			.m_ready  (m_ready[j]),
			.stall    (stall[j])
		);
	end

	assign ring_link[0] = ring_link[station_num];  // close the ring.

	// whole ring moves or nothing does.
	assign advance = ~|stall;

	// ##################################################
	// checks

	// the token is neither lost nor duplicated on its way round.
	a_one_token: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot({gen_src[3].u_src.token_q, gen_src[2].u_src.token_q,
			gen_src[1].u_src.token_q, gen_src[0].u_src.token_q}));

	// every beat leaves at its sink before the ring wraps.
	a_ring_drained: assert property (@(posedge clk) disable iff (!rst_n)
		!ring_link[station_num].valid);

endmodule

//--- include/ring_bus_tb_vectors.svh
// Ring bus switch stimulus table.
// Packets offered by the source drivers, in table order per source.
// Each entry gives source, destination sink, length in beats (1 to 5)
// and a data seed; beat n of a packet carries seed plus n.

`ifndef RING_BUS_TB_VECTORS_SVH
`define RING_BUS_TB_VECTORS_SVH

typedef struct packed {
	ring_bus_pkg::src_id_t src;
	ring_bus_pkg::dst_id_t dst;
	logic [2:0]            len;
	ring_bus_pkg::data_t   seed;
} tb_packet_t;

localparam int tb_packet_num = 16;

localparam tb_packet_t tb_packets [tb_packet_num] = '{
	'{2'd0, 2'd1, 3'd3, 16'h1000},
	'{2'd1, 2'd0, 3'd5, 16'h2000},
	'{2'd2, 2'd2, 3'd1, 16'h3000},
	'{2'd3, 2'd1, 3'd4, 16'h4000},
	'{2'd0, 2'd2, 3'd2, 16'h1100},
	'{2'd1, 2'd1, 3'd1, 16'h2100},
	'{2'd2, 2'd0, 3'd5, 16'h3100},
	'{2'd3, 2'd2, 3'd3, 16'h4100},
	'{2'd0, 2'd0, 3'd4, 16'h1200},
	'{2'd1, 2'd2, 3'd2, 16'h2200},
	'{2'd2, 2'd1, 3'd3, 16'h3200},
	'{2'd3, 2'd0, 3'd1, 16'h4200},
	'{2'd0, 2'd1, 3'd5, 16'h1300},
	'{2'd1, 2'd0, 3'd3, 16'h2300},
	'{2'd2, 2'd2, 3'd2, 16'h3300},
	'{2'd3, 2'd1, 3'd5, 16'h4300}
};

`endif

//--- verification/ring_bus_switch_tb.sv
// Ring bus stream switch testbench.
// Four source drivers replay the packet table at the same time, the sinks
// apply random back-pressure, and a scoreboard with one expected queue per
// source and sink pair checks routing, order, packet integrity and hold.

`timescale 1ns/1ps

module ring_bus_switch_tb;
	import ring_bus_pkg::*;

	`include "ring_bus_tb_vectors.svh"

	localparam int cycle_limit = 4000;  // delivery timeout in clock cycles.
	localparam int idle_cycles = 20;

	logic               clk;
	logic               rst_n;
	src_beat_t          s_beat [src_num];
	logic [src_num-1:0] s_valid;
	logic [src_num-1:0] s_ready;
	dst_beat_t          m_beat [dst_num];
	logic [dst_num-1:0] m_valid;
	logic [dst_num-1:0] m_ready;

	src_beat_t          src_q [src_num][$];          // beats still to offer.
	dst_beat_t          exp_q [src_num*dst_num][$];  // per source and sink pair.
	logic [src_num-1:0] sent;
	logic [dst_num-1:0] waiting;
	dst_beat_t          held_beat [dst_num];
	logic [dst_num-1:0] in_packet;
	src_id_t            packet_src [dst_num];
	logic [31:0]        rng;
	int                 pending;

	ring_bus_switch uut (
		.clk     (clk),
		.rst_n   (rst_n),
		.s_beat  (s_beat),
		.s_valid (s_valid),
		.s_ready (s_ready),
		.m_beat  (m_beat),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ##################################################
	// helpers

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Test failures found");
		$display("Fail at %0t ns: %s", $time, msg);
		$fatal(1);
	endtask

	task automatic report_hang(input string msg);
		$display("Test failures found");
		$display("Timed out: %s", msg);
		$fatal(1);
	endtask

	task automatic check_idle(input string where);
		assert (m_valid == '0)
			else report_mismatch($sformatf("m_valid is %b %s", m_valid, where));
	endtask

	// present the next beat of each source and draw a new m_ready.
	task automatic drive_inputs();
		for (int i = 0; i < src_num; i++) begin
			if (sent[i])
				void'(src_q[i].pop_front());
			sent[i] = 1'b0;
			if (src_q[i].size() > 0) begin
				s_beat[i]  = src_q[i][0];
				s_valid[i] = 1'b1;
			end else begin
				s_beat[i]  = '0;
				s_valid[i] = 1'b0;
			end
		end
		rng = xorshift(rng);
		for (int j = 0; j < dst_num; j++)
			m_ready[j] = (rng[4*j +: 2] != 2'b00);  // ready about 3 of 4 cycles.
	endtask

	task automatic check_delivery(input int j, input dst_beat_t beat);
		int        idx;
		dst_beat_t exp;
		idx = int'(beat.src_id) * dst_num + j;
		assert (exp_q[idx].size() > 0)
			else report_mismatch($sformatf(
				"unexpected beat %h at sink %0d from source %0d",
				beat.data, j, beat.src_id));
		exp = exp_q[idx].pop_front();
		assert (beat == exp)
			else report_mismatch($sformatf("sink %0d got %h, expected %h",
				j, beat, exp));
		// a packet in progress owns the sink until its last beat.
		if (in_packet[j]) begin
			assert (beat.src_id == packet_src[j])
				else report_mismatch($sformatf(
					"sink %0d: source %0d inside packet of source %0d",
					j, beat.src_id, packet_src[j]));
		end
		in_packet[j]  = !beat.last;
		packet_src[j] = beat.src_id;
		pending--;
	endtask

	// called at the falling edge when all inputs and outputs are settled.
	task automatic sample_cycle();
		logic stalled;
		stalled = |(m_valid & ~m_ready);
		// only the token holder may inject, and nobody while the ring stalls.
		assert ($onehot0(s_ready) && !(stalled && s_ready != '0))
			else report_mismatch($sformatf("s_ready is %b with m_valid %b and m_ready %b",
				s_ready, m_valid, m_ready));
		for (int i = 0; i < src_num; i++)
			sent[i] = s_valid[i] && s_ready[i];
		for (int j = 0; j < dst_num; j++) begin
			if (waiting[j]) begin
				assert (m_valid[j] && m_beat[j] == held_beat[j])
					else report_mismatch($sformatf(
						"sink %0d dropped or changed a waiting beat", j));
			end
			if (m_valid[j] && m_ready[j])
				check_delivery(j, m_beat[j]);
			waiting[j]   = m_valid[j] && !m_ready[j];
			held_beat[j] = m_beat[j];
		end
	endtask

	// ##################################################
	// main sequence

	initial begin
		tb_packet_t pkt;
		src_beat_t  sb;
		dst_beat_t  db;
		int         cycle;

		rst_n     = 1'b0;
		s_valid   = '0;
		m_ready   = '0;
		sent      = '0;
		waiting   = '0;
		in_packet = '0;
		rng       = 32'h5bb863d2;
		pending   = 0;
		for (int i = 0; i < src_num; i++)
			s_beat[i] = '0;
		for (int j = 0; j < dst_num; j++) begin
			held_beat[j]  = '0;
			packet_src[j] = '0;
		end

		// expand the table into beats per source and per pair.
		for (int p = 0; p < tb_packet_num; p++) begin
			pkt = tb_packets[p];
			for (int n = 0; n < int'(pkt.len); n++) begin
				sb.dst_id = pkt.dst;
				sb.last   = (n == int'(pkt.len) - 1);
				sb.data   = pkt.seed + data_t'(n);
				src_q[pkt.src].push_back(sb);
				db.src_id = pkt.src;
				db.last   = sb.last;
				db.data   = sb.data;
				exp_q[int'(pkt.src) * dst_num + int'(pkt.dst)].push_back(db);
				pending++;
			end
		end

		repeat (4) begin
			@(posedge clk);
			@(negedge clk);
			check_idle("during reset");
		end
		@(posedge clk);  // fifth reset edge.
		#1;
		rst_n = 1'b1;
		drive_inputs();

		cycle = 0;
		while (pending > 0) begin
			@(negedge clk);
			if (cycle == 0)
				check_idle("in the first cycle after reset");
			sample_cycle();
			@(posedge clk);
			#1;
			drive_inputs();
			cycle++;
			if (cycle >= cycle_limit)
				report_hang($sformatf("%0d beats still undelivered", pending));
		end

		// the ring must drain completely once the table is done.
		for (int k = 0; k < idle_cycles; k++) begin
			@(negedge clk);
			check_idle("after the last packet");
			@(posedge clk);
			#1;
			drive_inputs();
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
src/ring_bus_pkg.sv
src/ring_bus_source_station.sv
src/ring_bus_sink_station.sv
src/ring_bus_switch.sv
verification/ring_bus_switch_tb.sv

//--- Bender.yml
package:
  name: ring_bus_switch

sources:
  - files:
      - src/ring_bus_pkg.sv
      - src/ring_bus_source_station.sv
      - src/ring_bus_sink_station.sv
      - src/ring_bus_switch.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/ring_bus_switch_tb.sv
